// File: project.f
ow_pkg.sv
ow_cmd_split.sv
ow_data_fifo.sv
ow_tlp_ctrl.sv
ow_hdr_build.sv
ow_tlp_out.sv
ow_top.sv
ow_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the outbound write path testbench with Verilator.
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing -f project.f --top-module ow_tb -o ow_sim --Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ow_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
exit 1

// File: ow_tb.sv
`timescale 1ns/1ns

module ow_tb;
    import ow_pkg::*;

    localparam int TIMEOUT = 200;    // cycles without progress before a wait gives up.

    logic     clk;
    logic     rst;
    logic     aw_valid;
    dw_addr_t aw_addr;
    axi_len_t aw_len;
    logic     aw_ready;
    logic     w_valid;
    dword_t   w_data;
    strb_t    w_strb;
    logic     w_ready;
    logic     tlp_valid;
    dword_t   tlp_data;
    logic     tlp_last;
    logic     tlp_ready;

    int       seed = 16426;
    int       checks = 0;
    int       errors = 0;
    logic     ready_gaps;
    logic     abort;

    dword_t   bdata [16];            // staging for the burst being queued.
    strb_t    bstrb [16];
    dw_addr_t q_addr [$];
    axi_len_t q_len [$];
    dword_t   q_data [$];
    strb_t    q_strb [$];
    dword_t   exp_data [$];
    logic     exp_last [$];
    dword_t   pay_q [$];             // payload of the TLP the model is collecting.
    dw_addr_t tlp_addr;
    strb_t    tlp_first;
    strb_t    tlp_lbe;

    ow_top DUT (
        .clk(clk), .rst(rst),
        .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_len(aw_len), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_data(w_data), .w_strb(w_strb), .w_ready(w_ready),
        .tlp_valid(tlp_valid), .tlp_data(tlp_data), .tlp_last(tlp_last),
        .tlp_ready(tlp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic close_tlp();
        int k;
        exp_data.push_back({20'h0, tlp_lbe, tlp_first, tlp_len_t'(pay_q.size())});
        exp_last.push_back(1'b0);
        exp_data.push_back({tlp_addr, 2'b00});
        exp_last.push_back(1'b0);
        for (k = 0; k < pay_q.size(); k++) begin
            exp_data.push_back(pay_q[k]);
            exp_last.push_back(k == pay_q.size() - 1);
        end
        pay_q.delete();
    endtask

    task automatic model_burst(input dw_addr_t addr, input axi_len_t len);
        dw_addr_t a;
        logic     prev_full;
        logic     cont;
        int       i;
        prev_full = 1'b0;
        for (i = 0; i <= int'(len); i++) begin
            a    = addr + dw_addr_t'(i);
            cont = (i > 0) && (a[11:2] != 10'd0);     // offset zero starts a new page.
            if (pay_q.size() > 0 && !(cont && prev_full)) close_tlp();
            if (pay_q.size() == 0) begin
                tlp_addr  = a;
                tlp_first = bstrb[i];
                tlp_lbe   = 4'h0;
            end else begin
                tlp_lbe = bstrb[i];
            end
            pay_q.push_back(bdata[i]);
            prev_full = (bstrb[i] == 4'hf);
            if (i == int'(len) || pay_q.size() == MAX_TLP_DW
                    || (bstrb[i] != 4'hf && pay_q.size() > 1)) begin
                close_tlp();
            end
        end
    endtask

    task automatic queue_burst(input dw_addr_t addr, input axi_len_t len);
        int i;
        q_addr.push_back(addr);
        q_len.push_back(len);
        for (i = 0; i <= int'(len); i++) begin
            q_data.push_back(bdata[i]);
            q_strb.push_back(bstrb[i]);
        end
        model_burst(addr, len);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus, receive and compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t tlp_last got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        aw_valid  = 1'b0;
        w_valid   = 1'b0;
        tlp_ready = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic send_burst(input dw_addr_t addr, input axi_len_t len);
        int   i;
        int   t;
        logic hs;
        aw_valid = 1'b1;
        aw_addr  = addr;
        aw_len   = len;
        for (i = 0; i <= int'(len) && !abort; i++) begin
            w_valid = 1'b1;
            w_data  = q_data.pop_front();
            w_strb  = q_strb.pop_front();
            hs      = 1'b0;
            for (t = 0; t < TIMEOUT && !hs && !abort; t++) begin
                @(negedge clk);
                hs = w_ready;                  // ready is settled well before the edge.
                // the AW command is taken together with the first W beat.
                if (hs && i == 0) check_ready("aw_ready", aw_ready, 1'b1);
                @(posedge clk);
                #2;
            end
            if (!hs && !abort) begin
                $display("timeout: W beat %0d of the burst at %h was never accepted", i, addr);
                errors++;
                abort = 1'b1;
            end
            aw_valid = 1'b0;                   // AW goes with the first beat.
        end
        w_valid = 1'b0;
    endtask

    task automatic send_all();
        dw_addr_t addr;
        axi_len_t len;
        while (q_addr.size() > 0 && !abort) begin
            addr = q_addr.pop_front();
            len  = q_len.pop_front();
            send_burst(addr, len);
        end
    endtask

    task automatic recv_tlp();
        logic done;
        logic el;
        int   idle;
        done = 1'b0;
        idle = 0;
        while (!done && !abort) begin
            tlp_ready = ready_gaps ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge clk);
            if (tlp_valid && tlp_ready) begin
                idle = 0;
                el   = exp_last.pop_front();
                check_dword("tlp_data", tlp_data, exp_data.pop_front());
                check_last(tlp_last, el);
                done = el;
            end else if (++idle > TIMEOUT) begin
                $display("timeout: no output beat for %0d cycles", TIMEOUT);
                errors++;
                abort = 1'b1;
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_traffic(input logic gaps);
        int   k;
        logic extra;
        ready_gaps = gaps;
        abort      = 1'b0;
        extra      = 1'b0;
        fork
            send_all();
            while (exp_data.size() > 0 && !abort) recv_tlp();
        join
        tlp_ready = 1'b0;
        for (k = 0; k < 20; k++) begin
            @(negedge clk);
            if (tlp_valid && !extra && !abort) begin
                $display("output stream shows a beat the model did not predict");
                errors++;
                extra = 1'b1;
            end
        end
        @(posedge clk);
        #2;
        q_addr.delete();
        q_len.delete();
        q_data.delete();
        q_strb.delete();
        exp_data.delete();
        exp_last.delete();
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_single();
        int e;
        e = errors;
        apply_reset();
        bdata[0] = $random(seed);
        bstrb[0] = 4'h6;
        queue_burst(30'h0000_0100, 4'd0);
        run_traffic(1'b0);
        report_test("single dword write", e);
    endtask

    task automatic test_burst(input string name, input dw_addr_t addr, input axi_len_t len,
                              input int partial_at, input strb_t partial_strb);
        int e;
        int i;
        e = errors;
        apply_reset();
        for (i = 0; i <= int'(len); i++) begin
            bdata[i] = $random(seed);
            bstrb[i] = (i == partial_at) ? partial_strb : 4'hf;
        end
        if (partial_at >= 0) bstrb[partial_at + 1] = 4'he;   // next TLP opens partial.
        queue_burst(addr, len);
        run_traffic(1'b0);
        report_test(name, e);
    endtask

    task automatic test_random();
        int       e;
        int       b;
        int       i;
        dw_addr_t addr;
        axi_len_t len;
        e = errors;
        apply_reset();
        for (b = 0; b < 8; b++) begin
            addr = dw_addr_t'($random(seed));
            if (b[0]) addr[11:6] = 6'h3f;      // close to the end of a page.
            len = axi_len_t'($random(seed));
            for (i = 0; i <= int'(len); i++) begin
                bdata[i] = $random(seed);
                bstrb[i] = (($random(seed) & 7) == 0) ? strb_t'($random(seed)) : 4'hf;
            end
            queue_burst(addr, len);
        end
        run_traffic(1'b1);
        report_test("random bursts with output stalls", e);
    endtask

    initial begin
        rst       = 1'b1;
        aw_valid  = 1'b0;
        aw_addr   = '0;
        aw_len    = '0;
        w_valid   = 1'b0;
        w_data    = '0;
        w_strb    = '0;
        tlp_ready = 1'b0;
        test_single();
        test_burst("16 beat burst", 30'h0004_0010, 4'd15, -1, 4'hf);
        test_burst("page crossing", 30'h0000_13fe, 4'd3, -1, 4'hf);
        test_burst("partial middle strobe", 30'h0000_0200, 4'd5, 2, 4'h3);
        test_random();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: ow_top.sv
`timescale 1ns/1ns

module ow_top (
    input  logic             clk,
    input  logic             rst,

    input  logic             aw_valid,
    input  ow_pkg::dw_addr_t aw_addr,
    input  ow_pkg::axi_len_t aw_len,
    output logic             aw_ready,

    input  logic             w_valid,
    input  ow_pkg::dword_t   w_data,
    input  ow_pkg::strb_t    w_strb,
    output logic             w_ready,

    output logic             tlp_valid,
    output ow_pkg::dword_t   tlp_data,
    output logic             tlp_last,
    input  logic             tlp_ready
);
    import ow_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal nets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic     cmd_valid;
    logic     cmd_ready;
    dw_addr_t cmd_addr;
    logic     cmd_addr_cont;
    strb_t    cmd_strb;
    logic     cmd_last;
    logic     hdr_start;
    logic     hdr_add;
    logic     emit_start;
    logic     emit_done;
    dw_addr_t hdr_addr;
    tlp_len_t hdr_len;
    strb_t    hdr_first_be;
    strb_t    hdr_last_be;
    logic     fifo_wr;
    logic     fifo_rd;
    dword_t   fifo_data;

    assign fifo_wr = w_valid && w_ready;    // data is queued on every W transfer.

    ow_cmd_split u_split (
        .clk(clk), .rst(rst),
        .aw_ready(aw_ready), .aw_valid(aw_valid), .aw_addr(aw_addr), .aw_len(aw_len),
        .w_ready(w_ready), .w_valid(w_valid), .w_strb(w_strb),
        .cmd_ready(cmd_ready), .cmd_valid(cmd_valid), .cmd_addr(cmd_addr),
        .cmd_addr_cont(cmd_addr_cont), .cmd_strb(cmd_strb), .cmd_last(cmd_last)
    );

    ow_data_fifo u_fifo (
        .clk(clk), .rst(rst),
        .wr(fifo_wr), .wr_data(w_data), .rd(fifo_rd), .rd_data(fifo_data)
    );

    ow_tlp_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_addr_cont(cmd_addr_cont), .cmd_strb(cmd_strb),
        .cmd_last(cmd_last), .cmd_ready(cmd_ready),
        .hdr_start(hdr_start), .hdr_add(hdr_add),
        .emit_start(emit_start), .emit_done(emit_done)
    );

    ow_hdr_build u_hdr (
        .clk(clk), .rst(rst),
        .hdr_start(hdr_start), .hdr_add(hdr_add), .cmd_addr(cmd_addr), .cmd_strb(cmd_strb),
        .hdr_addr(hdr_addr), .hdr_len(hdr_len),
        .hdr_first_be(hdr_first_be), .hdr_last_be(hdr_last_be)
    );

    ow_tlp_out u_out (
        .clk(clk), .rst(rst),
        .emit_start(emit_start), .hdr_addr(hdr_addr), .hdr_len(hdr_len),
        .hdr_first_be(hdr_first_be), .hdr_last_be(hdr_last_be),
        .fifo_data(fifo_data), .fifo_rd(fifo_rd), .emit_done(emit_done),
        .tlp_valid(tlp_valid), .tlp_data(tlp_data), .tlp_last(tlp_last),
        .tlp_ready(tlp_ready)
    );

endmodule

// File: ow_tlp_out.sv
`timescale 1ns/1ns

module ow_tlp_out (
    input  logic             clk,
    input  logic             rst,
    input  logic             emit_start,
    input  ow_pkg::dw_addr_t hdr_addr,
    input  ow_pkg::tlp_len_t hdr_len,
    input  ow_pkg::strb_t    hdr_first_be,
    input  ow_pkg::strb_t    hdr_last_be,
    input  ow_pkg::dword_t   fifo_data,
    output logic             fifo_rd,
    output logic             emit_done,
    output logic             tlp_valid,
    output ow_pkg::dword_t   tlp_data,
    output logic             tlp_last,
    input  logic             tlp_ready
);
    import ow_pkg::*;

    logic  busy;
    beat_t beat;     // 0 and 1 are header, payload follows.
    logic  xfer;

    assign tlp_valid = busy;
    assign xfer      = tlp_valid && tlp_ready;
    assign tlp_last  = busy && (beat == beat_t'(hdr_len) + beat_t'(1));
    assign fifo_rd   = xfer && (beat >= beat_t'(2));
    assign emit_done = xfer && tlp_last;

    always_comb begin
        tlp_data = '0;
        case (beat)
            beat_t'(0): begin
                tlp_data[3:0]  = hdr_len;
                tlp_data[7:4]  = hdr_first_be;
                tlp_data[11:8] = hdr_last_be;
            end
            beat_t'(1): tlp_data = {hdr_addr, 2'b00};
            default:    tlp_data = fifo_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (emit_start) begin
            busy <= 1'b1;
            beat <= '0;
        end else if (xfer) begin
            if (tlp_last) busy <= 1'b0;
            beat <= beat + beat_t'(1);
        end
    end

endmodule

// File: ow_hdr_build.sv
`timescale 1ns/1ns

module ow_hdr_build (
    input  logic             clk,
    input  logic             rst,
    input  logic             hdr_start,
    input  logic             hdr_add,
    input  ow_pkg::dw_addr_t cmd_addr,
    input  ow_pkg::strb_t    cmd_strb,
    output ow_pkg::dw_addr_t hdr_addr,
    output ow_pkg::tlp_len_t hdr_len,
    output ow_pkg::strb_t    hdr_first_be,
    output ow_pkg::strb_t    hdr_last_be
);
    import ow_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_len <= '0;
        end else if (hdr_start) begin
            hdr_len <= tlp_len_t'(1);
        end else if (hdr_add) begin
            hdr_len <= hdr_len + tlp_len_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_start) begin
            hdr_addr     <= cmd_addr;
            hdr_first_be <= cmd_strb;
            hdr_last_be  <= '0;           // a one-dword TLP has no last_be.
        end else if (hdr_add) begin
            hdr_last_be  <= cmd_strb;
        end
    end

endmodule

// File: ow_tlp_ctrl.sv
`timescale 1ns/1ns

module ow_tlp_ctrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          cmd_valid,
    input  logic          cmd_addr_cont,
    input  ow_pkg::strb_t cmd_strb,
    input  logic          cmd_last,
    output logic          cmd_ready,
    output logic          hdr_start,
    output logic          hdr_add,
    output logic          emit_start,
    input  logic          emit_done
);
    import ow_pkg::*;

    tlp_state_t state;
    tlp_len_t   dw_cnt;
    logic       prev_full;    // last accepted strobe had all four bytes.

    logic       can_join;
    logic       take;
    tlp_len_t   next_cnt;
    logic       close_after;

    assign can_join = cmd_addr_cont && prev_full;

    always_comb begin
        case (state)
            IDLE:    cmd_ready = 1'b1;
            COLLECT: cmd_ready = can_join;
            default: cmd_ready = 1'b0;
        endcase
    end

    assign take      = cmd_valid && cmd_ready;
    assign hdr_start = take && (state == IDLE);
    assign hdr_add   = take && (state == COLLECT);
    assign next_cnt  = (state == IDLE) ? tlp_len_t'(1) : dw_cnt + tlp_len_t'(1);

    // a partial strobe may only be the last dword once the TLP has more than one.
    assign close_after = cmd_last
                      || (next_cnt == tlp_len_t'(MAX_TLP_DW))
                      || (!(&cmd_strb) && (next_cnt > tlp_len_t'(1)));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            dw_cnt     <= '0;
            prev_full  <= 1'b0;
            emit_start <= 1'b0;
        end else begin
            emit_start <= 1'b0;
            if (take) begin
                dw_cnt    <= next_cnt;
                prev_full <= &cmd_strb;
            end
            case (state)
                IDLE, COLLECT: begin
                    if (take) begin
                        state      <= close_after ? EMIT : COLLECT;
                        emit_start <= close_after;
                    end else if (state == COLLECT && cmd_valid) begin
                        state      <= EMIT;    // command waits to open the next TLP.
                        emit_start <= 1'b1;
                    end
                end
                EMIT: begin
                    if (emit_done) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: ow_data_fifo.sv
`timescale 1ns/1ns

module ow_data_fifo (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr,
    input  ow_pkg::dword_t wr_data,
    input  logic           rd,
    output ow_pkg::dword_t rd_data
);
    import ow_pkg::*;

    dword_t    mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      wr_en;
    logic      rd_en;

    assign wr_en   = wr && (count != fifo_cnt_t'(FIFO_DEPTH));
    assign rd_en   = rd && (count != '0);
    assign rd_data = mem[rd_ptr];                 // head word is always visible.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            if (rd_en) rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            case ({wr_en, rd_en})
                2'b10:   count <= count + fifo_cnt_t'(1);
                2'b01:   count <= count - fifo_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: ow_cmd_split.sv
`timescale 1ns/1ns

module ow_cmd_split (
    input  logic             clk,
    input  logic             rst,

    output logic             aw_ready,
    input  logic             aw_valid,
    input  ow_pkg::dw_addr_t aw_addr,
    input  ow_pkg::axi_len_t aw_len,

    output logic             w_ready,
    input  logic             w_valid,
    input  ow_pkg::strb_t    w_strb,

    input  logic             cmd_ready,
    output logic             cmd_valid,
    output ow_pkg::dw_addr_t cmd_addr,
    output logic             cmd_addr_cont,
    output ow_pkg::strb_t    cmd_strb,
    output logic             cmd_last
);
    import ow_pkg::*;

    dw_addr_t addr_p1;       // dword after cmd_addr, carried across page boundaries.
    axi_len_t beats_left;

    dw_addr_t next_addr;
    logic     next_cont;
    axi_len_t next_left;
    logic     next_last;
    logic     beat_avail;
    logic     update;

    always_comb begin
        if (cmd_last) begin
            // the previous burst has finished, so this beat opens a new one.
            next_addr = aw_addr;
            next_left = aw_len;
            next_last = (aw_len == '0);
        end else begin
            next_addr = addr_p1;
            next_left = beats_left - axi_len_t'(1);
            next_last = (beats_left == axi_len_t'(1));
        end
        // a dword at offset zero of its page never continues the previous one.
        next_cont = (next_addr == addr_p1) && (addr_p1[11:2] != '0);
    end

    assign beat_avail = w_valid && (!cmd_last || aw_valid);
    assign update     = beat_avail && (!cmd_valid || cmd_ready);
    assign aw_ready   = update && cmd_last;     // AW goes with the first beat of a burst.
    assign w_ready    = update;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
            cmd_last  <= 1'b1;
        end else begin
            if (update) begin
                cmd_valid <= 1'b1;
                cmd_last  <= next_last;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            cmd_addr      <= next_addr;
            cmd_addr_cont <= next_cont;
            cmd_strb      <= w_strb;
            addr_p1       <= next_addr + dw_addr_t'(1);
            beats_left    <= next_left;
        end
    end

endmodule

// File: ow_pkg.sv
package ow_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and limits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W     = 32;
    localparam int LEN_W      = 4;        // a burst is len+1 beats.
    localparam int MAX_TLP_DW = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int BEAT_W     = $clog2(MAX_TLP_DW + 2);  // two header beats plus payload.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [ADDR_W-1:2]  dw_addr_t;   // bits 11:2 are the dword offset in a 4 KB page.
    typedef logic [LEN_W-1:0]   axi_len_t;
    typedef logic [3:0]         strb_t;
    typedef logic [31:0]        dword_t;
    typedef logic [3:0]         tlp_len_t;   // holds 1 to MAX_TLP_DW.
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;
    typedef logic [BEAT_W-1:0]  beat_t;

    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        EMIT
    } tlp_state_t;

endpackage
